// File: rtl/mem_pkg.sv
`default_nettype none

// geometry of the scratch RAM and the shape of its write port
package mem_pkg;

   // ------------------------------------------------------------------
   // geometry
   // ------------------------------------------------------------------
   localparam int mem_addr_w = 10;                       // word address bits
   localparam int mem_data_w = 32;                       // bits per word
   localparam int mem_lanes  = 4;                        // byte lanes per word
   localparam int mem_lane_w = mem_data_w / mem_lanes;   // 8 bits per lane
   localparam int mem_depth  = 1 << mem_addr_w;          // 1024 words

   typedef logic [mem_addr_w-1:0] mem_addr_t;
   typedef logic [mem_data_w-1:0] mem_data_t;
   typedef logic [mem_lanes-1:0]  mem_be_t;             // one enable per lane

   // ------------------------------------------------------------------
   // write port, 46 bits
   // ------------------------------------------------------------------
   typedef struct packed {
      mem_addr_t addr;   // word address
      mem_data_t data;   // full word, lanes picked by be
      mem_be_t   be;     // byte lane enables
   } ram_wr_t;

endpackage

`default_nettype wire

// File: rtl/axi_pkg.sv
`default_nettype none

// AXI field widths, codes and channel payloads
package axi_pkg;

   // ------------------------------------------------------------------
   // field widths
   // ------------------------------------------------------------------
   localparam int axi_id_w  = 4;
   localparam int axi_len_w = 4;   // beats = len + 1, so 1 to 16

   typedef logic [axi_id_w-1:0]  axi_id_t;
   typedef logic [axi_len_w-1:0] axi_len_t;
   typedef logic [1:0]           axi_burst_t;
   typedef logic [1:0]           axi_resp_t;

   // burst types, wrap is not supported
   localparam axi_burst_t burst_fixed = 2'd0;   // every beat on one word
   localparam axi_burst_t burst_incr  = 2'd1;   // one word per beat

   localparam axi_resp_t  resp_okay   = 2'd0;
   localparam axi_resp_t  resp_slverr = 2'd2;   // wlast on the wrong beat

   // ------------------------------------------------------------------
   // channel payloads
   // ------------------------------------------------------------------
   typedef struct packed {
      axi_id_t            id;
      mem_pkg::mem_addr_t addr;    // word address, no byte offset
      axi_len_t           len;
      axi_burst_t         burst;
   } axi_addr_t;                    // used for both aw and ar

   typedef struct packed {
      mem_pkg::mem_data_t data;
      mem_pkg::mem_be_t   strb;
      logic               last;
   } axi_wdata_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } axi_bresp_t;

   typedef struct packed {
      axi_id_t            id;
      mem_pkg::mem_data_t data;
      axi_resp_t          resp;
      logic               last;
   } axi_rdata_t;

endpackage

`default_nettype wire

// File: rtl/scratch_ram.sv
`default_nettype none

// word RAM, one write port with lane enables and one registered read port
module scratch_ram (
   input  wire                 clock,
   input  wire mem_pkg::ram_wr_t  wr,        // address, data and lane enables
   input  wire                 we,
   input  wire mem_pkg::mem_addr_t rd_addr,
   output mem_pkg::mem_data_t  rd_data     // valid one cycle after rd_addr
);

   import mem_pkg::*;

   mem_data_t mem [mem_depth];   // one word per address

   // ------------------------------------------------------------------
   // write side
   // ------------------------------------------------------------------
   always_ff @(posedge clock) begin
      if (we) begin
         for (int i = 0; i < mem_lanes; i++) begin
            if (wr.be[i])                                 // only strobed lanes change
               mem[wr.addr][i*mem_lane_w +: mem_lane_w] <= wr.data[i*mem_lane_w +: mem_lane_w];
         end
      end
   end

   // ------------------------------------------------------------------
   // read side
   // ------------------------------------------------------------------
   // same-cycle write to rd_addr gives the old word
   always_ff @(posedge clock) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: rtl/axi_write_ctrl.sv
`default_nettype none

// write side of the memory slave
// one transaction at a time, address first, then data, then response
module axi_write_ctrl (
   input  wire                    clock,
   input  wire                    rst,
   // write address
   input  wire axi_pkg::axi_addr_t  aw,
   input  wire                    aw_valid,
   output logic                   aw_ready,
   // write data
   input  wire axi_pkg::axi_wdata_t w,
   input  wire                    w_valid,
   output logic                   w_ready,
   // write response
   output axi_pkg::axi_bresp_t    b,
   output logic                   b_valid,
   input  wire                    b_ready,
   // RAM write port
   output mem_pkg::ram_wr_t       ram_wr,
   output logic                   ram_we
);

   import axi_pkg::*;
   import mem_pkg::*;

   typedef enum logic [1:0] {
      W_IDLE,    // waiting for aw
      W_BURST,   // taking beats
      W_RESP     // holding b until b_ready
   } wstate_t;

   wstate_t    state;

   // captured address channel
   axi_id_t    id_q;
   mem_addr_t  addr_q;      // address of the next beat
   axi_burst_t burst_q;
   axi_len_t   left_q;      // beats left after the current one

   logic       aw_hs;
   logic       beat;        // accepted data beat
   logic       final_beat;  // burst ends on this beat

   assign aw_hs      = aw_valid && aw_ready;
   assign beat       = w_valid && w_ready;
   assign final_beat = w.last || (left_q == '0);   // early last or beat len+1

   // ------------------------------------------------------------------
   // RAM write, straight from the beat
   // ------------------------------------------------------------------
   assign ram_wr = '{addr: addr_q, data: w.data, be: w.strb};
   assign ram_we = beat;   // w_ready is only high in W_BURST

   // ------------------------------------------------------------------
   // control
   // ------------------------------------------------------------------
   always_ff @(posedge clock or negedge rst) begin
      if (!rst) begin
         state    <= W_IDLE;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         b_valid  <= 1'b0;
      end else begin
         case (state)
            W_IDLE: begin
               aw_ready <= 1'b1;        // rises the first cycle out of reset
               if (aw_hs) begin
                  aw_ready <= 1'b0;
                  w_ready  <= 1'b1;     // data accepted from the next cycle
                  state    <= W_BURST;
               end
            end
            W_BURST: begin
               if (beat && final_beat) begin
                  w_ready <= 1'b0;
                  b_valid <= 1'b1;      // response the cycle after the final beat
                  state   <= W_RESP;
               end
            end
            W_RESP: begin
               if (b_ready) begin       // b_valid is high all through W_RESP
                  b_valid  <= 1'b0;
                  aw_ready <= 1'b1;     // next address the cycle after the B handshake
                  state    <= W_IDLE;
               end
            end
            default: state <= W_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------------
   // payload, address stepping and response
   // ------------------------------------------------------------------
   always_ff @(posedge clock) begin
      if (aw_hs) begin
         id_q    <= aw.id;
         addr_q  <= aw.addr;
         burst_q <= aw.burst;
         left_q  <= aw.len;
      end else if (beat) begin
         if (burst_q == burst_incr)
            addr_q <= addr_q + 1'b1;   // wraps at the top of the RAM
         left_q <= left_q - 1'b1;      // underflow on the final beat is harmless
      end

      // okay only when last lands exactly on beat len+1
      if (beat && final_beat)
         b <= '{id: id_q, resp: (w.last && left_q == '0) ? resp_okay : resp_slverr};
   end

endmodule

`default_nettype wire

// File: rtl/axi_read_ctrl.sv
`default_nettype none

// read side of the memory slave
// RAM output and the prefetch register keep two words in flight
module axi_read_ctrl (
   input  wire                    clock,
   input  wire                    rst,
   // read address
   input  wire axi_pkg::axi_addr_t  ar,
   input  wire                    ar_valid,
   output logic                   ar_ready,
   // read data
   output axi_pkg::axi_rdata_t    r,
   output logic                   r_valid,
   input  wire                    r_ready,
   // RAM read port
   output mem_pkg::mem_addr_t     rd_addr,
   input  wire mem_pkg::mem_data_t  rd_data   // word for last cycle's rd_addr
);

   import axi_pkg::*;
   import mem_pkg::*;

   typedef enum logic [1:0] {
      R_IDLE,    // waiting for ar, first word read on the handshake
      R_FILL,    // first word on rd_data, second one being read
      R_BURST,   // streaming beats
      R_LAST     // final beat on r
   } rstate_t;

   rstate_t              state;

   // captured address channel
   axi_id_t              id_q;
   mem_addr_t            base_q;
   axi_burst_t           burst_q;
   axi_len_t             len_q;

   logic [axi_len_w:0]   fcnt;      // beat index of the word on rd_data
   logic [axi_len_w:0]   fidx;      // beat index read this cycle
   axi_len_t             dcnt;      // beat index of the word on r
   mem_data_t            pf_data;   // prefetch register, feeds r.data
   logic                 last_q;

   logic                 ar_hs;
   logic                 beat;
   logic                 advance;   // pipeline moves one word

   assign ar_hs   = ar_valid && ar_ready;
   assign beat    = r_valid && r_ready;
   assign advance = (state == R_FILL) || (state == R_BURST && r_ready);
   assign fidx    = advance ? fcnt + 1'b1 : fcnt;   // on a stall the same word is reread

   // ------------------------------------------------------------------
   // RAM address
   // ------------------------------------------------------------------
   always_comb begin
      if (state == R_IDLE)
         rd_addr = ar.addr;                        // word 0 leaves on the handshake
      else if (burst_q == burst_incr)
         rd_addr = base_q + mem_addr_t'(fidx);     // wraps modulo the RAM size
      else
         rd_addr = base_q;                         // fixed burst
   end

   // all fields come from registers, so r holds under back-pressure
   assign r = '{id: id_q, data: pf_data, resp: resp_okay, last: last_q};

   // ------------------------------------------------------------------
   // control
   // ------------------------------------------------------------------
   always_ff @(posedge clock or negedge rst) begin
      if (!rst) begin
         state    <= R_IDLE;
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
         last_q   <= 1'b0;
      end else begin
         case (state)
            R_IDLE: begin
               ar_ready <= 1'b1;
               if (ar_hs) begin
                  ar_ready <= 1'b0;
                  state    <= R_FILL;
               end
            end
            R_FILL: begin
               r_valid <= 1'b1;                    // 2 cycles after the handshake
               last_q  <= (len_q == '0);
               state   <= (len_q == '0) ? R_LAST : R_BURST;
            end
            R_BURST: begin
               if (r_ready && (dcnt + 1'b1 == len_q)) begin
                  last_q <= 1'b1;                  // next beat is len+1
                  state  <= R_LAST;
               end
            end
            R_LAST: begin
               if (r_ready) begin
                  r_valid  <= 1'b0;
                  last_q   <= 1'b0;
                  ar_ready <= 1'b1;                // cycle after the last beat
                  state    <= R_IDLE;
               end
            end
         endcase
      end
   end

   // ------------------------------------------------------------------
   // payload and counters
   // ------------------------------------------------------------------
   always_ff @(posedge clock) begin
      if (ar_hs) begin
         id_q    <= ar.id;
         base_q  <= ar.addr;
         burst_q <= ar.burst;
         len_q   <= ar.len;
         fcnt    <= '0;
      end else if (advance) begin
         fcnt    <= fidx;
      end

      if (advance)
         pf_data <= rd_data;   // holds while r_ready is low

      if (state == R_FILL)
         dcnt <= '0;
      else if (beat && state == R_BURST)
         dcnt <= dcnt + 1'b1;
   end

endmodule

`default_nettype wire

// File: rtl/axi_mem_top.sv
`default_nettype none

// AXI scratch memory slave, write and read controllers around one RAM
module axi_mem_top (
   input  wire                    clock,
   input  wire                    rst,
   // write address
   input  wire axi_pkg::axi_addr_t  aw,
   input  wire                    aw_valid,
   output logic                   aw_ready,
   // write data
   input  wire axi_pkg::axi_wdata_t w,
   input  wire                    w_valid,
   output logic                   w_ready,
   // write response
   output axi_pkg::axi_bresp_t    b,
   output logic                   b_valid,
   input  wire                    b_ready,
   // read address
   input  wire axi_pkg::axi_addr_t  ar,
   input  wire                    ar_valid,
   output logic                   ar_ready,
   // read data
   output axi_pkg::axi_rdata_t    r,
   output logic                   r_valid,
   input  wire                    r_ready
);

   import mem_pkg::*;

   // ------------------------------------------------------------------
   // RAM links
   // ------------------------------------------------------------------
   ram_wr_t   ram_wr;    // write ctrl to RAM
   logic      ram_we;
   mem_addr_t rd_addr;   // read ctrl to RAM
   mem_data_t rd_data;   // one cycle behind rd_addr

   axi_write_ctrl u_wr (
      .clock    (clock),
      .rst      (rst),
      .aw       (aw),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .w        (w),
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .b        (b),
      .b_valid  (b_valid),
      .b_ready  (b_ready),
      .ram_wr   (ram_wr),
      .ram_we   (ram_we)
   );

   axi_read_ctrl u_rd (
      .clock    (clock),
      .rst      (rst),
      .ar       (ar),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .r        (r),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data)
   );

   scratch_ram u_ram (
      .clock    (clock),
      .wr       (ram_wr),
      .we       (ram_we),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data)
   );

endmodule

`default_nettype wire

// File: testbench/axi_mem_asserts.sv
`default_nettype none

// handshake rules of the memory slave, bound into axi_mem_top
module axi_mem_asserts (
   input wire                      clock,
   input wire                      rst,
   input wire                      aw_ready,
   input wire axi_pkg::axi_bresp_t b,
   input wire                      b_valid,
   input wire                      b_ready,
   input wire axi_pkg::axi_rdata_t r,
   input wire                      r_valid,
   input wire                      r_ready
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;   // failed assertions so far

   // b holds while the master stalls it
   assert property (@(posedge clock) disable iff (!rst)
                    b_valid && !b_ready |=> b_valid && $stable(b))
      else begin
         $error("b changed or dropped before b_ready");
         fail_count++;
      end

   // r payload frozen under back-pressure
   assert property (@(posedge clock) disable iff (!rst)
                    r_valid && !r_ready |=> r_valid && $stable(r))
      else begin
         $error("r changed or dropped while r_ready was low");
         fail_count++;
      end

   // no new write address while a response is pending
   assert property (@(posedge clock) disable iff (!rst) b_valid |-> !aw_ready)
      else begin
         $error("aw_ready high during a pending write response");
         fail_count++;
      end

   assert property (@(posedge clock) disable iff (!rst) r.last |-> r_valid)
      else begin
         $error("r.last set without r_valid");
         fail_count++;
      end

endmodule

bind axi_mem_top axi_mem_asserts u_asserts (
   .clock    (clock),
   .rst      (rst),
   .aw_ready (aw_ready),
   .b        (b),
   .b_valid  (b_valid),
   .b_ready  (b_ready),
   .r        (r),
   .r_valid  (r_valid),
   .r_ready  (r_ready)
);

`default_nettype wire

// File: testbench/tb_axi_mem.sv
`default_nettype none

// random AXI traffic against a word-array model of the scratch RAM
module tb_axi_mem;

   timeunit 1ns;
   timeprecision 100ps;

   import axi_pkg::*;
   import mem_pkg::*;

   localparam int clk_period = 40;
   // transactions per test, used to size the watchdog
   localparam int n_preload  = 64;          // 64 bursts of 16 words cover the RAM
   localparam int n_single   = 16;          // write + read each
   localparam int n_incr     = 12;          // write + read each
   localparam int n_fixed    = 8;           // write + read each
   localparam int n_press    = 12;          // reads only
   localparam int n_early    = 6;           // bad write, read, good write
   localparam int n_latency  = 6;           // reads only
   localparam int n_total    = n_preload + 2*n_single + 2*n_incr + 2*n_fixed
                               + n_press + 3*n_early + n_latency;

   logic       clock, rst;
   axi_addr_t  aw, ar;
   axi_wdata_t w;
   axi_bresp_t b;
   axi_rdata_t r;
   logic       aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
   logic       ar_valid, ar_ready, r_valid, r_ready;

   mem_data_t  model [mem_depth];           // expected RAM contents
   logic [31:0] lcg_state;
   int         checks, errors, tests;
   int         chk0, err0;                  // counts at the start of the current test

   axi_mem_top UUT (.*);

   initial begin
      clock = 1'b0;
      forever #(clk_period / 2) clock = ~clock;
   end

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic int rand_below(int n);
      logic [31:0] v;
      v = lcg_next();
      return int'(v[30:16]) % n;            // upper bits, low ones cycle fast
   endfunction

   task automatic tick();
      @(posedge clock);
      #5;                                   // inputs change here, outputs already settled
   endtask

   task automatic check(string name, logic [31:0] got, logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(string name);
      tests++;
      $display("test %0d %s: %0d checks, %0d errors", tests, name, checks - chk0,
               errors - err0);
      chk0 = checks;
      err0 = errors;
   endtask

   // ------------------------------------------------------------------
   // one write, wlast goes on beat last_beat (past len means never)
   // ------------------------------------------------------------------
   task automatic write_burst(axi_id_t id, mem_addr_t addr, axi_len_t len, axi_burst_t burst,
                              int last_beat, logic gaps, logic full);
      int        nbeats;
      logic      rdy;
      mem_addr_t a;
      mem_data_t d;
      mem_be_t   s;
      axi_resp_t exp_resp;
      nbeats   = (last_beat < int'(len)) ? last_beat + 1 : int'(len) + 1;
      exp_resp = (last_beat == int'(len)) ? resp_okay : resp_slverr;
      aw       = '{id: id, addr: addr, len: len, burst: burst};
      aw_valid = 1'b1;
      do begin
         rdy = aw_ready;                    // ready seen now is sampled on the next edge
         tick();
      end while (!rdy);
      aw_valid = 1'b0;
      a = addr;
      for (int i = 0; i < nbeats; i++) begin
         if (gaps && rand_below(3) == 0) begin
            w_valid = 1'b0;                 // idle cycles between beats
            repeat (1 + rand_below(2)) tick();
         end
         d = lcg_next();
         s = full ? '1 : mem_be_t'(rand_below(16));
         w = '{data: d, strb: s, last: (i == last_beat)};
         w_valid = 1'b1;
         do begin
            rdy = w_ready;
            tick();
         end while (!rdy);
         for (int k = 0; k < mem_lanes; k++)
            if (s[k]) model[a][k*mem_lane_w +: mem_lane_w] = d[k*mem_lane_w +: mem_lane_w];
         if (burst == burst_incr)
            a = a + 1'b1;                   // wraps like the RAM
      end
      w_valid = 1'b0;
      while (!b_valid) tick();
      repeat (rand_below(3)) tick();        // hold off b_ready a little
      b_ready = 1'b1;
      check("b.id", 32'(b.id), 32'(id));
      check("b.resp", 32'(b.resp), 32'(exp_resp));
      tick();
      b_ready = 1'b0;
   endtask

   // ------------------------------------------------------------------
   // one read, pressure is the percent of cycles with r_ready low
   // ------------------------------------------------------------------
   task automatic read_burst(axi_id_t id, mem_addr_t addr, axi_len_t len, axi_burst_t burst,
                             int pressure, logic timing);
      int        beat;
      int        lat;
      logic      rdy;
      mem_addr_t a;
      ar       = '{id: id, addr: addr, len: len, burst: burst};
      ar_valid = 1'b1;
      do begin
         rdy = ar_ready;
         tick();
      end while (!rdy);
      ar_valid = 1'b0;
      beat = 0;
      lat  = 1;                             // edges from the AR handshake
      a    = addr;
      while (beat <= int'(len)) begin
         r_ready = (rand_below(100) >= pressure);
         if (r_valid && r_ready) begin
            check("r.data", r.data, model[a]);
            check("r.id", 32'(r.id), 32'(id));
            check("r.resp", 32'(r.resp), 32'(resp_okay));
            check("r.last", 32'(r.last), 32'(beat == int'(len)));
            if (timing && beat == 0)
               check("read latency", lat, 2);
            beat++;
            if (burst == burst_incr)
               a = a + 1'b1;
         end else if (timing && beat > 0) begin
            check("r_valid", 32'(r_valid), 1);   // gap inside a streaming burst
         end
         tick();
         lat++;
      end
      r_ready = 1'b0;
   endtask

   // ------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------
   initial begin
      mem_addr_t a;
      axi_len_t  len;
      int        last;
      lcg_state = 32'd18;
      checks = 0;
      errors = 0;
      tests  = 0;
      chk0   = 0;
      err0   = 0;
      rst = 1'b0;
      aw = '0;
      aw_valid = 1'b0;
      w = '0;
      w_valid = 1'b0;
      b_ready = 1'b0;
      ar = '0;
      ar_valid = 1'b0;
      r_ready = 1'b0;
      repeat (3) @(posedge clock);
      #5;
      rst = 1'b1;

      // full words everywhere, so partial strobes later land on known data
      for (int i = 0; i < n_preload; i++)
         write_burst(4'(i), mem_addr_t'(i * 16), 4'd15, burst_incr, 15, 1'b0, 1'b1);
      end_test("preload");

      for (int i = 0; i < n_single; i++) begin
         a = mem_addr_t'(rand_below(mem_depth));
         write_burst(axi_id_t'(rand_below(16)), a, '0, burst_incr, 0, 1'b0, 1'b0);
         read_burst(axi_id_t'(rand_below(16)), a, '0, burst_incr, 0, 1'b0);
      end
      end_test("single beat writes");

      for (int i = 0; i < n_incr; i++) begin
         a   = mem_addr_t'(rand_below(mem_depth));
         len = axi_len_t'(rand_below(16));
         write_burst(axi_id_t'(rand_below(16)), a, len, burst_incr, int'(len), 1'b1, 1'b0);
         read_burst(axi_id_t'(rand_below(16)), a, len, burst_incr, 0, 1'b0);
      end
      end_test("incr bursts");

      for (int i = 0; i < n_fixed; i++) begin
         a   = mem_addr_t'(rand_below(mem_depth));
         len = axi_len_t'(1 + rand_below(7));
         write_burst(axi_id_t'(rand_below(16)), a, len, burst_fixed, int'(len), 1'b1, 1'b0);
         read_burst(axi_id_t'(rand_below(16)), a, '0, burst_fixed, 0, 1'b0);
      end
      end_test("fixed bursts");

      for (int i = 0; i < n_press; i++) begin
         read_burst(axi_id_t'(rand_below(16)), mem_addr_t'(rand_below(mem_depth)),
                    axi_len_t'(rand_below(16)), rand_below(2) ? burst_incr : burst_fixed,
                    50, 1'b0);
      end
      end_test("read back-pressure");

      for (int i = 0; i < n_early; i++) begin
         a    = mem_addr_t'(rand_below(mem_depth));
         len  = axi_len_t'(2 + rand_below(14));
         last = rand_below(int'(len));      // before the declared final beat
         write_burst(axi_id_t'(rand_below(16)), a, len, burst_incr, last, 1'b0, 1'b0);
         read_burst(axi_id_t'(rand_below(16)), a, axi_len_t'(last), burst_incr, 0, 1'b0);
         write_burst(axi_id_t'(rand_below(16)), a, len, burst_incr, int'(len), 1'b0, 1'b0);
      end
      end_test("early wlast");

      for (int i = 0; i < n_latency; i++) begin
         read_burst(axi_id_t'(rand_below(16)), mem_addr_t'(rand_below(mem_depth)),
                    axi_len_t'(rand_below(16)), burst_incr, 0, 1'b1);
      end
      end_test("read latency");

      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
               errors, UUT.u_asserts.fail_count);
      if (errors == 0 && UUT.u_asserts.fail_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // 40 cycles per transaction is far above any single burst
   initial begin
      #(n_total * 40 * clk_period);
      $display("watchdog expired after %0d cycles, the DUT stopped responding", n_total * 40);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
rtl/mem_pkg.sv
rtl/axi_pkg.sv
rtl/scratch_ram.sv
rtl/axi_write_ctrl.sv
rtl/axi_read_ctrl.sv
rtl/axi_mem_top.sv
testbench/axi_mem_asserts.sv
testbench/tb_axi_mem.sv

// File: Makefile
# Verilator build and run for the AXI scratch memory

VERILATOR ?= verilator
TOP       ?= tb_axi_mem
DUT_TOP   ?= axi_mem_top
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD) -o V$(TOP)

run: build
	./$(BUILD)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
